// ==== hdl/rvm_pkg.sv ====
package rvm_pkg;

    // ----------------------------------------
    // Widths and vector types
    // ----------------------------------------

    localparam int xlen = 32;                       // Data path width.
    localparam int reg_addr_w = 5;                  // Register index width.

    typedef logic [xlen-1:0]       word_t;          // Data word or byte address.
    typedef logic [reg_addr_w-1:0] reg_addr_t;      // Register file index.
    typedef logic [xlen-1:0]       imm_t;           // Sign-extended immediate.

    // ----------------------------------------
    // Decoded operations and unit selects
    // ----------------------------------------

    typedef enum logic [3:0] {
        op_add,
        op_sub,
        op_and,
        op_or,
        op_xor,
        op_addi,
        op_andi,
        op_ori,
        op_xori,
        op_lui,
        op_illegal                                  // Anything not listed above.
    } op_e;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_imm                                     // Pass immediate, for LUI.
    } alu_sel_e;

    typedef enum logic [2:0] {
        post_reset,
        fetch,
        decode,
        execute,
        inc_pc
    } ctrl_state_e;

    // Right hand operand sources of the arithmetic unit.
    localparam logic [1:0] rhs_src_rs2  = 2'd0;
    localparam logic [1:0] rhs_src_imm  = 2'd1;
    localparam logic [1:0] rhs_src_step = 2'd2;

    // ----------------------------------------
    // Instruction encodings
    // ----------------------------------------

    localparam logic [6:0] opcode_op     = 7'b0110011;  // Register-register.
    localparam logic [6:0] opcode_op_imm = 7'b0010011;  // Register-immediate.
    localparam logic [6:0] opcode_lui    = 7'b0110111;

    localparam logic [2:0] funct3_add = 3'b000;     // Also SUB and ADDI.
    localparam logic [2:0] funct3_xor = 3'b100;
    localparam logic [2:0] funct3_or  = 3'b110;
    localparam logic [2:0] funct3_and = 3'b111;

    localparam logic [6:0] funct7_sub = 7'b0100000;

    localparam word_t pc_step  = 32'd4;
    localparam word_t reset_pc = 32'd0;
    localparam word_t ir_reset = 32'd0;             // Opcode zero decodes as illegal.

endpackage

// ==== hdl/rvm_decode.sv ====
`timescale 1ns/100ps

module rvm_decode import rvm_pkg::*; (
    input  logic      clk,
    input  logic      resetn,

    input  logic      i_ir_load,                    // Capture the fetched word.
    input  word_t     i_mem_rdata,                  // Word from memory.

    output op_e       o_op,                         // Decoded operation.
    output reg_addr_t o_rs1_addr,
    output reg_addr_t o_rs2_addr,
    output reg_addr_t o_rd_addr,
    output imm_t      o_imm                         // I-type or U-type immediate.
);

    word_t      ir;                                 // Instruction register.
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    // ----------------------------------------
    // Instruction register
    // ----------------------------------------

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            ir <= ir_reset;
        end else if (i_ir_load) begin
            ir <= i_mem_rdata;
        end
    end

    // ----------------------------------------
    // Field extraction
    // ----------------------------------------

    assign opcode = ir[6:0];
    assign funct3 = ir[14:12];
    assign funct7 = ir[31:25];

    assign o_rd_addr  = ir[11:7];
    assign o_rs1_addr = ir[19:15];
    assign o_rs2_addr = ir[24:20];

    // U-type for LUI, otherwise the sign-extended I-type field.
    assign o_imm = (opcode == opcode_lui) ? {ir[31:12], 12'b0} :
                                            {{20{ir[31]}}, ir[31:20]};

    // ----------------------------------------
    // Operation decode
    // ----------------------------------------

    always_comb begin
        o_op = op_illegal;
        case (opcode)
            opcode_op: begin
                if (funct7 == 7'b0) begin
                    case (funct3)
                        funct3_add: o_op = op_add;
                        funct3_xor: o_op = op_xor;
                        funct3_or:  o_op = op_or;
                        funct3_and: o_op = op_and;
                        default:    o_op = op_illegal;  // Shifts and compares.
                    endcase
                end else if (funct7 == funct7_sub && funct3 == funct3_add) begin
                    o_op = op_sub;
                end
            end
            opcode_op_imm: begin
                case (funct3)
                    funct3_add: o_op = op_addi;
                    funct3_xor: o_op = op_xori;
                    funct3_or:  o_op = op_ori;
                    funct3_and: o_op = op_andi;
                    default:    o_op = op_illegal;
                endcase
            end
            opcode_lui: o_op = op_lui;
            default:    o_op = op_illegal;
        endcase
    end

    // The IR only loads from a completed fetch, so an X here means bad memory data.
    a_ir_known: assert property (@(posedge clk) disable iff (!resetn)
        !$isunknown(ir));

endmodule

// ==== hdl/rvm_regfile.sv ====
`timescale 1ns/100ps

module rvm_regfile import rvm_pkg::*; (
    input  logic      clk,
    input  logic      resetn,

    input  reg_addr_t i_rs1_addr,
    input  reg_addr_t i_rs2_addr,

    input  reg_addr_t i_rd_addr,
    input  logic      i_rd_wen,                     // Write enable, one cycle.
    input  word_t     i_rd_wdata,

    output word_t     o_rs1_rdata,
    output word_t     o_rs2_rdata
);

    word_t regs [32];                               // x0 is held at zero.

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_rd_wen && i_rd_addr != '0) begin
            regs[i_rd_addr] <= i_rd_wdata;
        end
    end

    // Asynchronous read ports.
    assign o_rs1_rdata = (i_rs1_addr == '0) ? '0 : regs[i_rs1_addr];
    assign o_rs2_rdata = (i_rs2_addr == '0) ? '0 : regs[i_rs2_addr];

    // Control must never issue a write before decode has settled rd.
    a_wr_addr_known: assert property (@(posedge clk) disable iff (!resetn)
        i_rd_wen |-> !$isunknown(i_rd_addr));

endmodule

// ==== hdl/rvm_alu.sv ====
`timescale 1ns/100ps

module rvm_alu import rvm_pkg::*; (
    input  alu_sel_e   i_sel,                       // Operation to perform.
    input  logic       i_lhs_pc,                    // Left operand is the PC.
    input  logic [1:0] i_rhs_src,                   // Right operand source.

    input  word_t      i_pc,
    input  word_t      i_rs1_rdata,
    input  word_t      i_rs2_rdata,
    input  word_t      i_imm,

    output word_t      o_result
);

    logic  rhs_is_rs2;
    logic  rhs_is_imm;
    logic  rhs_is_step;
    word_t lhs;
    word_t rhs;

    // ----------------------------------------
    // Operand selection
    // ----------------------------------------

    assign rhs_is_rs2  = i_rhs_src == rhs_src_rs2;
    assign rhs_is_imm  = i_rhs_src == rhs_src_imm;
    assign rhs_is_step = i_rhs_src == rhs_src_step;

    assign lhs = {xlen{ i_lhs_pc}} & i_pc        |
                 {xlen{!i_lhs_pc}} & i_rs1_rdata;

    assign rhs = {xlen{rhs_is_rs2 }} & i_rs2_rdata |
                 {xlen{rhs_is_imm }} & i_imm       |
                 {xlen{rhs_is_step}} & pc_step;     // Unused encoding gives zero.

    // ----------------------------------------
    // Result
    // ----------------------------------------

    always_comb begin
        case (i_sel)
            alu_add: o_result = lhs + rhs;
            alu_sub: o_result = lhs - rhs;          // Wraps modulo 2^32.
            alu_and: o_result = lhs & rhs;
            alu_or:  o_result = lhs | rhs;
            alu_xor: o_result = lhs ^ rhs;
            alu_imm: o_result = i_imm;
            default: o_result = '0;
        endcase
    end

endmodule

// ==== hdl/rvm_control.sv ====
`timescale 1ns/100ps

module rvm_control import rvm_pkg::*; (
    input  logic       clk,
    input  logic       resetn,

    input  op_e        i_op,                        // Decoded operation.
    input  reg_addr_t  i_rd_addr,                   // Destination register.
    input  logic       i_mem_stall,                 // Memory not ready this cycle.
    input  word_t      i_alu_result,

    output logic       o_ir_load,                   // Instruction register load.
    output logic       o_mem_c_en,                  // Memory chip enable.
    output word_t      o_mem_addr,
    output word_t      o_pc,

    output alu_sel_e   o_alu_sel,
    output logic       o_lhs_pc,
    output logic [1:0] o_rhs_src,

    output logic       o_rd_wen,                    // Register write, execute only.
    output logic       o_illegal                    // Illegal word retired.
);

    ctrl_state_e ctrl_state;
    ctrl_state_e n_ctrl_state;
    word_t       pc;
    logic        in_fetch;
    logic        in_execute;
    logic        in_inc_pc;
    logic        op_legal;
    logic        op_is_reg;                         // Right operand from rs2.

    assign in_fetch   = ctrl_state == fetch;
    assign in_execute = ctrl_state == execute;
    assign in_inc_pc  = ctrl_state == inc_pc;

    assign op_legal  = i_op != op_illegal;
    assign op_is_reg = i_op inside {op_add, op_sub, op_and, op_or, op_xor};

    // ----------------------------------------
    // Next state
    // ----------------------------------------

    always_comb begin
        n_ctrl_state = ctrl_state;
        case (ctrl_state)
            post_reset: n_ctrl_state = fetch;
            fetch:      n_ctrl_state = i_mem_stall ? fetch : decode;
            decode:     n_ctrl_state = execute;
            execute:    n_ctrl_state = inc_pc;
            inc_pc:     n_ctrl_state = fetch;
            default:    n_ctrl_state = post_reset;
        endcase
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            ctrl_state <= post_reset;
        end else begin
            ctrl_state <= n_ctrl_state;
        end
    end

    // ----------------------------------------
    // Program counter
    // ----------------------------------------

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            pc <= reset_pc;
        end else if (in_inc_pc) begin
            pc <= i_alu_result;                     // PC plus step.
        end
    end

    assign o_pc = pc;

    // ----------------------------------------
    // Memory and decode
    // ----------------------------------------

    assign o_mem_c_en = in_fetch;
    assign o_mem_addr = {xlen{in_fetch}} & pc;
    assign o_ir_load  = in_fetch && !i_mem_stall;   // Fetch completes this edge.

    // ----------------------------------------
    // Arithmetic unit
    // ----------------------------------------

    always_comb begin
        o_alu_sel = alu_add;
        o_lhs_pc  = in_inc_pc;
        o_rhs_src = rhs_src_rs2;
        if (in_inc_pc) begin
            o_rhs_src = rhs_src_step;
        end else if (in_execute) begin
            o_rhs_src = op_is_reg ? rhs_src_rs2 : rhs_src_imm;
            case (i_op)
                op_add, op_addi: o_alu_sel = alu_add;
                op_sub:          o_alu_sel = alu_sub;
                op_and, op_andi: o_alu_sel = alu_and;
                op_or,  op_ori:  o_alu_sel = alu_or;
                op_xor, op_xori: o_alu_sel = alu_xor;
                op_lui:          o_alu_sel = alu_imm;
                default:         o_alu_sel = alu_add;
            endcase
        end
    end

    // ----------------------------------------
    // Retire
    // ----------------------------------------

    // Writes to x0 are dropped here so they never show on the retire port.
    assign o_rd_wen  = in_execute && op_legal && i_rd_addr != '0;
    assign o_illegal = in_execute && !op_legal;

    a_wdata_known: assert property (@(posedge clk) disable iff (!resetn)
        o_rd_wen |-> !$isunknown(i_alu_result));

    a_pc_aligned: assert property (@(posedge clk) disable iff (!resetn)
        pc[1:0] == 2'b00);

endmodule

// ==== hdl/rvm_core.sv ====
`timescale 1ns/100ps

module rvm_core import rvm_pkg::*; (
    input  logic      clk,
    input  logic      resetn,

    output logic      o_mem_c_en,                   // Instruction fetch request.
    output word_t     o_mem_addr,
    input  word_t     i_mem_rdata,
    input  logic      i_mem_stall,

    output logic      o_rd_wen,                     // Retire port.
    output reg_addr_t o_rd_addr,
    output word_t     o_rd_wdata,
    output logic      o_illegal
);

    logic       ir_load;
    op_e        op;
    reg_addr_t  rs1_addr;
    reg_addr_t  rs2_addr;
    imm_t       imm;
    word_t      rs1_rdata;
    word_t      rs2_rdata;
    word_t      pc;
    alu_sel_e   alu_sel;
    logic       lhs_pc;
    logic [1:0] rhs_src;

    rvm_decode u_decode (
        .clk         (clk),
        .resetn      (resetn),
        .i_ir_load   (ir_load),
        .i_mem_rdata (i_mem_rdata),
        .o_op        (op),
        .o_rs1_addr  (rs1_addr),
        .o_rs2_addr  (rs2_addr),
        .o_rd_addr   (o_rd_addr),
        .o_imm       (imm)
    );

    rvm_regfile u_regfile (
        .clk         (clk),
        .resetn      (resetn),
        .i_rs1_addr  (rs1_addr),
        .i_rs2_addr  (rs2_addr),
        .i_rd_addr   (o_rd_addr),
        .i_rd_wen    (o_rd_wen),
        .i_rd_wdata  (o_rd_wdata),
        .o_rs1_rdata (rs1_rdata),
        .o_rs2_rdata (rs2_rdata)
    );

    // Result feeds both the register write port and the PC.
    rvm_alu u_alu (
        .i_sel       (alu_sel),
        .i_lhs_pc    (lhs_pc),
        .i_rhs_src   (rhs_src),
        .i_pc        (pc),
        .i_rs1_rdata (rs1_rdata),
        .i_rs2_rdata (rs2_rdata),
        .i_imm       (imm),
        .o_result    (o_rd_wdata)
    );

    rvm_control u_control (
        .clk          (clk),
        .resetn       (resetn),
        .i_op         (op),
        .i_rd_addr    (o_rd_addr),
        .i_mem_stall  (i_mem_stall),
        .i_alu_result (o_rd_wdata),
        .o_ir_load    (ir_load),
        .o_mem_c_en   (o_mem_c_en),
        .o_mem_addr   (o_mem_addr),
        .o_pc         (pc),
        .o_alu_sel    (alu_sel),
        .o_lhs_pc     (lhs_pc),
        .o_rhs_src    (rhs_src),
        .o_rd_wen     (o_rd_wen),
        .o_illegal    (o_illegal)
    );

endmodule

// ==== bench/tb_rvm_program.svh ====
`ifndef TB_RVM_PROGRAM_SVH
`define TB_RVM_PROGRAM_SVH

// Columns: name, instruction word, illegal, write, rd, data.
// Registers start at zero, each entry sees the results of the ones above it.
task automatic load_program();
    add_test("addi_pos",       encode_i(12'h005, 5'd0, f3_add, 5'd1),
             1'b0, 1'b1, 5'd1,  32'h0000_0005);
    add_test("addi_neg",       encode_i(12'hFFD, 5'd0, f3_add, 5'd2),
             1'b0, 1'b1, 5'd2,  32'hFFFF_FFFD);
    add_test("lui",            encode_u(20'h12345, 5'd3),
             1'b0, 1'b1, 5'd3,  32'h1234_5000);
    add_test("addi_low",       encode_i(12'h678, 5'd3, f3_add, 5'd4),
             1'b0, 1'b1, 5'd4,  32'h1234_5678);
    add_test("lui_mask",       encode_u(20'hF0F0F, 5'd5),
             1'b0, 1'b1, 5'd5,  32'hF0F0_F000);
    add_test("add",            encode_r(f7_base, 5'd4, 5'd1, f3_add, 5'd6),
             1'b0, 1'b1, 5'd6,  32'h1234_567D);
    add_test("sub_wrap",       encode_r(f7_sub, 5'd4, 5'd1, f3_add, 5'd7),
             1'b0, 1'b1, 5'd7,  32'hEDCB_A98D);   // 5 minus x4 goes below zero.
    add_test("and",            encode_r(f7_base, 5'd5, 5'd4, f3_and, 5'd8),
             1'b0, 1'b1, 5'd8,  32'h1030_5000);
    add_test("or",             encode_r(f7_base, 5'd5, 5'd4, f3_or, 5'd9),
             1'b0, 1'b1, 5'd9,  32'hF2F4_F678);
    add_test("xor",            encode_r(f7_base, 5'd5, 5'd4, f3_xor, 5'd10),
             1'b0, 1'b1, 5'd10, 32'hE2C4_A678);
    add_test("andi_neg",       encode_i(12'hFF0, 5'd4, f3_and, 5'd11),
             1'b0, 1'b1, 5'd11, 32'h1234_5670);
    add_test("ori_neg",        encode_i(12'hF00, 5'd1, f3_or, 5'd12),
             1'b0, 1'b1, 5'd12, 32'hFFFF_FF05);
    add_test("xori_neg",       encode_i(12'hFFF, 5'd4, f3_xor, 5'd13),
             1'b0, 1'b1, 5'd13, 32'hEDCB_A987);
    add_test("addi_x0",        encode_i(12'h007, 5'd1, f3_add, 5'd0),
             1'b0, 1'b0, 5'd0,  32'h0000_0000);   // Write to x0 is dropped.
    add_test("add_x0",         encode_r(f7_base, 5'd2, 5'd0, f3_add, 5'd14),
             1'b0, 1'b1, 5'd14, 32'hFFFF_FFFD);   // x0 still reads zero.
    add_test("branch_illegal", 32'h0020_8463,
             1'b1, 1'b0, 5'd0,  32'h0000_0000);   // beq x1, x2, +8.
    add_test("after_illegal",  encode_i(12'h00A, 5'd2, f3_add, 5'd15),
             1'b0, 1'b1, 5'd15, 32'h0000_0007);
    add_test("sub_small",      encode_r(f7_sub, 5'd1, 5'd15, f3_add, 5'd16),
             1'b0, 1'b1, 5'd16, 32'h0000_0002);
    add_test("xor_ones",       encode_r(f7_base, 5'd6, 5'd7, f3_xor, 5'd17),
             1'b0, 1'b1, 5'd17, 32'hFFFF_FFF0);
endtask

`endif

// ==== bench/tb_rvm_core.sv ====
`timescale 1ns/100ps

module tb_rvm_core;

    localparam int max_tests       = 32;
    localparam int reset_cycles    = 16;
    localparam int cycles_per_test = 8;            // Worst case fetch is 4 cycles.
    localparam int spare_cycles    = 20;

    // RV32I encoding fields.
    localparam logic [2:0] f3_add  = 3'b000;
    localparam logic [2:0] f3_xor  = 3'b100;
    localparam logic [2:0] f3_or   = 3'b110;
    localparam logic [2:0] f3_and  = 3'b111;
    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_sub  = 7'b0100000;

    logic        clk;
    logic        resetn;
    logic        mem_stall;
    logic [31:0] mem_rdata;
    logic        o_mem_c_en;
    logic [31:0] o_mem_addr;
    logic        o_rd_wen;
    logic [4:0]  o_rd_addr;
    logic [31:0] o_rd_wdata;
    logic        o_illegal;

    string       test_name   [max_tests];
    logic [31:0] test_word   [max_tests];
    logic        exp_illegal [max_tests];
    logic        exp_wen     [max_tests];
    logic [4:0]  exp_rd      [max_tests];
    logic [31:0] exp_data    [max_tests];
    int          num_tests    = 0;

    int          error_count  = 0;
    int          pass_count   = 0;
    int          fail_count   = 0;
    int          retire_count = 0;
    int          cycle_count  = 0;
    int          stall_left   = 0;
    logic [31:0] lfsr_state   = 32'h34486415;

    rvm_core UUT (
        .clk         (clk),
        .resetn      (resetn),
        .o_mem_c_en  (o_mem_c_en),
        .o_mem_addr  (o_mem_addr),
        .i_mem_rdata (mem_rdata),
        .i_mem_stall (mem_stall),
        .o_rd_wen    (o_rd_wen),
        .o_rd_addr   (o_rd_addr),
        .o_rd_wdata  (o_rd_wdata),
        .o_illegal   (o_illegal)
    );

    // ----------------------------------------
    // Encoders and table access
    // ----------------------------------------

    function automatic logic [31:0] encode_r(input logic [6:0] funct7, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] funct3,
                                             input logic [4:0] rd);
        return {funct7, rs2, rs1, funct3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] encode_i(input logic [11:0] imm, input logic [4:0] rs1,
                                             input logic [2:0] funct3, input logic [4:0] rd);
        return {imm, rs1, funct3, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] encode_u(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, 7'b0110111};
    endfunction

    task automatic add_test(input string name, input logic [31:0] word, input logic illegal,
                            input logic wen, input logic [4:0] rd, input logic [31:0] data);
        test_name[num_tests]   = name;
        test_word[num_tests]   = word;
        exp_illegal[num_tests] = illegal;
        exp_wen[num_tests]     = wen;
        exp_rd[num_tests]      = rd;
        exp_data[num_tests]    = data;
        num_tests++;
    endtask

    `include "tb_rvm_program.svh"

    // Beyond the program the address comes back, its low bits never form a legal opcode.
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        int index;
        index = int'(addr[31:2]);
        if (index < num_tests) begin
            return test_word[index];
        end
        return addr;
    endfunction

    assign mem_rdata = mem_word(o_mem_addr);       // Memory answers combinationally.

    // ----------------------------------------
    // Random stall
    // ----------------------------------------

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    task automatic draw_stall_cycles(output int cycles);
        lfsr_state = lfsr_next(lfsr_state);
        cycles = lfsr_state[0];
        lfsr_state = lfsr_next(lfsr_state);
        cycles = cycles * 2 + lfsr_state[0];       // 0 to 3 cycles.
    endtask

    always @(posedge clk) begin
        if (o_mem_c_en && !mem_stall) begin
            draw_stall_cycles(stall_left);         // Next fetch.
            mem_stall <= (stall_left != 0);
        end else if (o_mem_c_en && mem_stall) begin
            stall_left = stall_left - 1;
            mem_stall <= (stall_left != 0);
        end
    end

    // ----------------------------------------
    // Clock, monitors and timeout
    // ----------------------------------------

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(negedge clk) begin
        if (resetn && (o_rd_wen || o_illegal)) begin
            retire_count++;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= reset_cycles + cycles_per_test * num_tests + spare_cycles) begin
            $display("Timeout after %0d cycles, the core stopped fetching", cycle_count);
            $display("Something failed");
            $finish;
        end
    end

    task automatic compare_value(input string test, input string field,
                                 input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %s %s: expected 0x%08h, actual 0x%08h",
                     test, field, expected, actual);
            error_count++;
        end
    endtask

    // Returns in the last cycle of fetch, the one whose closing edge loads the IR.
    task automatic wait_fetch();
        @(negedge clk);
        while (!(o_mem_c_en && !mem_stall)) begin
            @(negedge clk);
        end
    endtask

    task automatic run_test(input int t);
        int errors_before;
        errors_before = error_count;
        wait_fetch();
        compare_value(test_name[t], "fetch address", t * 4, o_mem_addr);
        repeat (2) @(negedge clk);                 // Decode, then execute.
        compare_value(test_name[t], "illegal", exp_illegal[t], o_illegal);
        compare_value(test_name[t], "write enable", exp_wen[t], o_rd_wen);
        compare_value(test_name[t], "mem enable", 1'b0, o_mem_c_en);
        if (exp_wen[t]) begin
            compare_value(test_name[t], "rd", exp_rd[t], o_rd_addr);
            compare_value(test_name[t], "data", exp_data[t], o_rd_wdata);
        end
        if (error_count == errors_before) begin
            pass_count++;
            $display("%-16s passed", test_name[t]);
        end else begin
            fail_count++;
            $display("%-16s failed", test_name[t]);
        end
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------

    initial begin
        int expected_retires;
        resetn = 1'b0;
        load_program();
        draw_stall_cycles(stall_left);
        mem_stall = (stall_left != 0);
        repeat (reset_cycles) @(posedge clk);
        resetn <= 1'b1;
        expected_retires = 0;
        for (int t = 0; t < num_tests; t++) begin
            if (exp_wen[t] || exp_illegal[t]) begin
                expected_retires++;
            end
            run_test(t);
        end
        @(negedge clk);                            // Let the last pulse be counted.
        compare_value("retire", "pulse count", expected_retires, retire_count);
        $display("%0d tests, %0d passed, %0d failed, %0d errors",
                 num_tests, pass_count, fail_count, error_count);
        if (error_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+bench
hdl/rvm_pkg.sv
hdl/rvm_decode.sv
hdl/rvm_regfile.sv
hdl/rvm_alu.sv
hdl/rvm_control.sv
hdl/rvm_core.sv
bench/tb_rvm_core.sv
